// ==== logic/pc_bus_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared pc bus definitions
// status encoding of the s2..s0 lines
// command strobe struct and address type
// clock divider and vector constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package pc_bus_pkg;

   // clock constants
   localparam int cpu_clk_div      = 21;                     // 100 MHz / 21 is about 4.76 MHz
   localparam int pclk_ratio       = 2;                      // peripheral clock is half rate
   localparam int cpu_div_w        = $clog2(cpu_clk_div);    // divider counter width
   localparam int pclk_w           = $clog2(pclk_ratio);     // peripheral phase width

   // interrupt vector layout
   localparam int vector_base_bits = 5;                      // upper vector bits from software

   // processor status lines s2_n s1_n s0_n
   typedef enum logic [2:0] {
      int_ack    = 3'd0,   // interrupt acknowledge
      io_read    = 3'd1,
      io_write   = 3'd2,
      halt       = 3'd3,   // no command issued
      code_fetch = 3'd4,   // memory read for opcode
      mem_read   = 3'd5,
      mem_write  = 3'd6,
      passive    = 3'd7    // no bus cycle
   } bus_status_e;

   // active low command strobes of the bus controller
   typedef struct packed {
      logic ior_n;   // io read
      logic iow_n;   // io write
      logic memr_n;  // memory read
      logic memw_n;  // memory write
      logic inta_n;  // interrupt acknowledge
   } bus_cmd_t;

   // latched system address
   typedef logic [19:0] addr_t;

   // all strobes released
   localparam bus_cmd_t cmd_idle = '{default: 1'b1};

endpackage

`default_nettype wire

// ==== logic/clock_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clock and ready generator
// processor and peripheral clock enables
// wait input sync into ready
// power good to processor reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module clock_gen (
   input  logic clk_100,      // 100 MHz board clock
   input  logic rst_n,
   input  logic pwr_good,     // async from supply
   input  logic rdy_wait_n,   // async wait request
   input  logic dma_wait_n,   // async wait from dma logic
   output logic cpu_clk_en,   // one pulse per processor clock
   output logic pclk_en,      // one pulse per peripheral clock
   output logic ready,
   output logic cpu_reset
);
   import pc_bus_pkg::*;

   logic [cpu_div_w-1:0] div_cnt;    // clk_100 cycles within a processor clock
   logic [pclk_w-1:0]    pclk_cnt;   // processor clocks within a peripheral clock
   logic                 tick_next;  // enable fires next cycle
   logic [1:0]           rdy_sync;
   logic [1:0]           dma_sync;
   logic [1:0]           pg_sync;

   assign tick_next = (div_cnt == cpu_div_w'(cpu_clk_div - 2)); // one early for registered enable

   // divider and enables
   always_ff @(posedge clk_100 or negedge rst_n) begin
      if (!rst_n) begin
         div_cnt    <= '0;
         pclk_cnt   <= '0;
         cpu_clk_en <= 1'b0;
         pclk_en    <= 1'b0;
      end else begin
         if (div_cnt == cpu_div_w'(cpu_clk_div - 1)) begin
            div_cnt <= '0;                                 // wrap every cpu_clk_div cycles
         end else begin
            div_cnt <= div_cnt + 1'b1;
         end
         cpu_clk_en <= tick_next;
         pclk_en    <= tick_next && (pclk_cnt == pclk_w'(pclk_ratio - 1)); // every second tick
         if (tick_next) begin
            if (pclk_cnt == pclk_w'(pclk_ratio - 1)) begin
               pclk_cnt <= '0;
            end else begin
               pclk_cnt <= pclk_cnt + 1'b1;
            end
         end
      end
   end

   // two flop synchronizers
   always_ff @(posedge clk_100 or negedge rst_n) begin
      if (!rst_n) begin
         rdy_sync <= '0;                                   // held in wait until seen
         dma_sync <= '0;
         pg_sync  <= '0;
      end else begin
         rdy_sync <= {rdy_sync[0], rdy_wait_n};
         dma_sync <= {dma_sync[0], dma_wait_n};
         pg_sync  <= {pg_sync[0], pwr_good};
      end
   end

   // outputs move only on processor clock
   always_ff @(posedge clk_100 or negedge rst_n) begin
      if (!rst_n) begin
         ready     <= 1'b0;
         cpu_reset <= 1'b1;                                // processor held in reset
      end else if (cpu_clk_en) begin
         ready     <= rdy_sync[1] & dma_sync[1];          // both wait sources released
         cpu_reset <= ~pg_sync[1];                         // follows power good
      end
   end

endmodule

`default_nettype wire

// ==== logic/bus_controller.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus controller
// status decode, ale, command strobes
// address latch and write data register
// data direction and return data mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module bus_controller (
   input  logic                    clk_100,
   input  logic                    rst_n,
   input  logic                    cpu_clk_en,   // processor clock enable
   input  logic                    aen_n,        // high while dma owns the bus
   input  pc_bus_pkg::bus_status_e s_n,
   input  logic [7:0]              ad_out,       // multiplexed address/data from cpu
   input  logic [19:8]             a_hi,
   input  logic [7:0]              sys_d_in,
   input  logic [7:0]              intc_data,
   input  logic                    intc_drive,
   output pc_bus_pkg::bus_cmd_t    cmd,
   output logic                    ale,
   output logic                    addr_oe,
   output logic                    sys_d_oe,
   output pc_bus_pkg::addr_t       addr,
   output logic [7:0]              sys_d_out,
   output logic [7:0]              cpu_d
);
   import pc_bus_pkg::*;

   typedef enum logic [1:0] {
      st_idle,   // waiting for a status after passive
      st_addr,   // address phase t1
      st_cmd     // strobe active until passive
   } bc_state_e;

   bc_state_e   state;
   bus_status_e stat_q;        // status latched at cycle start
   logic        prev_passive;  // last sample read passive
   logic        cycle_start;
   logic        strobe_on;
   logic        den;           // data enable
   logic        dtr;           // high for write direction
   addr_t       addr_q;
   logic [7:0]  wdata_q;

   // one strobe per status
   function automatic bus_cmd_t cmd_decode(input bus_status_e st);
      bus_cmd_t c;
      c = cmd_idle;
      case (st)
         int_ack:    c.inta_n = 1'b0;
         io_read:    c.ior_n  = 1'b0;
         io_write:   c.iow_n  = 1'b0;
         code_fetch: c.memr_n = 1'b0;   // fetch is a memory read
         mem_read:   c.memr_n = 1'b0;
         mem_write:  c.memw_n = 1'b0;
         default:    c = cmd_idle;      // halt and passive give no command
      endcase
      return c;
   endfunction

   assign cycle_start = cpu_clk_en && (state == st_idle) && prev_passive && !aen_n &&
                        (s_n != passive) && (s_n != halt);
   assign strobe_on   = cpu_clk_en && (state == st_addr) && !aen_n;

   always_ff @(posedge clk_100 or negedge rst_n) begin
      if (!rst_n) begin
         state        <= st_idle;
         stat_q       <= passive;
         prev_passive <= 1'b1;
         ale          <= 1'b0;
         cmd          <= cmd_idle;
         den          <= 1'b0;
         dtr          <= 1'b0;
      end else begin
         ale <= cycle_start;                                 // single cycle pulse
         if (cpu_clk_en) begin
            prev_passive <= (s_n == passive);
         end
         case (state)
            st_idle: begin
               if (cycle_start) begin
                  stat_q <= s_n;
                  dtr    <= (s_n == io_write) || (s_n == mem_write);
                  state  <= st_addr;
               end
            end
            st_addr: begin
               if (strobe_on) begin
                  cmd   <= cmd_decode(stat_q);                // one processor clock after ale
                  den   <= 1'b1;
                  state <= st_cmd;
               end else if (cpu_clk_en) begin
                  state <= st_idle;                           // bus taken away, drop cycle
               end
            end
            st_cmd: begin
               if (cpu_clk_en && (s_n == passive)) begin
                  cmd   <= cmd_idle;                          // release after passive sample
                  den   <= 1'b0;
                  state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // address latch and write data
   always_ff @(posedge clk_100) begin
      if (cycle_start) begin
         addr_q <= {a_hi, ad_out};                           // held until next start
      end
      if (strobe_on) begin
         wdata_q <= ad_out;                                  // data phase of the cpu bus
      end
   end

   assign addr      = addr_q;
   assign addr_oe   = ~aen_n;
   assign sys_d_out = wdata_q;
   assign sys_d_oe  = den & dtr;                             // drive system bus on writes only
   assign cpu_d     = intc_drive ? intc_data : sys_d_in;     // local pic wins over system bus

endmodule

`default_nettype wire

// ==== logic/interrupt_controller.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reduced interrupt controller
// mask and vector base registers
// edge requests and fixed priority
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module interrupt_controller (
   input  logic                 clk_100,
   input  logic                 rst_n,
   input  logic                 intr_cs_n,   // io decode for the pic
   input  logic                 xa0,         // register select
   input  pc_bus_pkg::bus_cmd_t cmd,
   input  logic [7:0]           ad_out,      // write data from cpu
   input  logic [7:0]           irq,
   output logic                 intr,
   output logic                 intc_drive,  // pic owns cpu data
   output logic [7:0]           intc_data
);
   import pc_bus_pkg::*;

   logic [7:0]                  mask_q;      // 1 masks the line
   logic [vector_base_bits-1:0] vbase_q;
   logic [7:0]                  req_q;       // request register
   logic [7:0]                  irq_q;       // previous irq for edge detect
   logic [7:0]                  pending;
   logic [7:0]                  clr_mask;
   logic [2:0]                  prio_num;
   logic [2:0]                  ack_num_q;   // number frozen for this ack
   logic [2:0]                  ack_num;
   logic                        ack_lock;
   logic                        iow_n_q;
   logic                        inta_n_q;
   logic                        wr_rise;
   logic                        ack_rise;
   logic                        ack_active;
   logic                        rd_sel;

   // lowest numbered line wins
   function automatic logic [2:0] lowest_set(input logic [7:0] v);
      logic [2:0] n;
      n = 3'd7;                               // nothing pending reads as ir7
      for (int i = 7; i >= 0; i--) begin
         if (v[i]) begin
            n = 3'(i);
         end
      end
      return n;
   endfunction

   assign pending    = req_q & ~mask_q;
   assign intr       = |pending;
   assign prio_num   = lowest_set(pending);
   assign ack_active = ~cmd.inta_n;
   assign ack_num    = ack_lock ? ack_num_q : prio_num;      // first ack cycle uses live value
   assign wr_rise    = cmd.iow_n & ~iow_n_q;                 // end of io write
   assign ack_rise   = cmd.inta_n & ~inta_n_q;               // end of acknowledge
   assign clr_mask   = {7'b0, ack_rise} << ack_num;
   assign rd_sel     = ~cmd.ior_n & ~intr_cs_n;

   always_ff @(posedge clk_100 or negedge rst_n) begin
      if (!rst_n) begin
         mask_q    <= 8'hff;                                 // all lines masked
         vbase_q   <= '0;
         req_q     <= '0;
         irq_q     <= '0;
         iow_n_q   <= 1'b1;
         inta_n_q  <= 1'b1;
         ack_lock  <= 1'b0;
         ack_num_q <= '0;
      end else begin
         iow_n_q  <= cmd.iow_n;
         inta_n_q <= cmd.inta_n;
         irq_q    <= irq;
         req_q    <= (req_q & ~clr_mask) | (irq & ~irq_q);   // set on rising irq
         if (wr_rise && !intr_cs_n) begin
            if (xa0) begin
               mask_q <= ad_out;
            end else begin
               vbase_q <= ad_out[7 -: vector_base_bits];
            end
         end
         if (ack_active && !ack_lock) begin
            ack_lock  <= 1'b1;
            ack_num_q <= prio_num;                           // hold vector stable during ack
         end else if (!ack_active) begin
            ack_lock  <= 1'b0;
         end
      end
   end

   // read and acknowledge data
   always_comb begin
      if (ack_active) begin
         intc_data = {vbase_q, ack_num};
      end else if (xa0) begin
         intc_data = mask_q;
      end else begin
         intc_data = req_q;
      end
   end

   assign intc_drive = ack_active | rd_sel;

endmodule

`default_nettype wire

// ==== logic/cpu_bus_sheet.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// processor sheet top level
// clock gen, bus controller, pic
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module cpu_bus_sheet (
   input  logic                    clk_100,     // board clock
   input  logic                    rst_n,
   input  pc_bus_pkg::bus_status_e s_n,         // from the cpu
   input  logic [7:0]              ad_out,
   input  logic [19:8]             a_hi,
   output logic [7:0]              cpu_d,       // back to the cpu
   input  logic [7:0]              sys_d_in,
   input  logic                    aen_n,
   input  logic                    intr_cs_n,
   input  logic                    xa0,
   input  logic [7:0]              irq,
   input  logic                    pwr_good,
   input  logic                    rdy_wait_n,
   input  logic                    dma_wait_n,
   output pc_bus_pkg::addr_t       addr,
   output logic                    addr_oe,
   output logic [7:0]              sys_d_out,
   output logic                    sys_d_oe,
   output pc_bus_pkg::bus_cmd_t    cmd,
   output logic                    ale,
   output logic                    intr,
   output logic                    ready,
   output logic                    cpu_reset,
   output logic                    cpu_clk_en,
   output logic                    pclk_en
);

   logic [7:0] intc_data;   // pic read and vector data
   logic       intc_drive;

   clock_gen clock_gen_i (
      .clk_100    (clk_100),
      .rst_n      (rst_n),
      .pwr_good   (pwr_good),
      .rdy_wait_n (rdy_wait_n),
      .dma_wait_n (dma_wait_n),
      .cpu_clk_en (cpu_clk_en),
      .pclk_en    (pclk_en),
      .ready      (ready),
      .cpu_reset  (cpu_reset)
   );

   bus_controller bus_controller_i (
      .clk_100    (clk_100),
      .rst_n      (rst_n),
      .cpu_clk_en (cpu_clk_en),
      .aen_n      (aen_n),
      .s_n        (s_n),
      .ad_out     (ad_out),
      .a_hi       (a_hi),
      .sys_d_in   (sys_d_in),
      .intc_data  (intc_data),
      .intc_drive (intc_drive),
      .cmd        (cmd),
      .ale        (ale),
      .addr_oe    (addr_oe),
      .sys_d_oe   (sys_d_oe),
      .addr       (addr),
      .sys_d_out  (sys_d_out),
      .cpu_d      (cpu_d)
   );

   interrupt_controller interrupt_controller_i (
      .clk_100    (clk_100),
      .rst_n      (rst_n),
      .intr_cs_n  (intr_cs_n),
      .xa0        (xa0),
      .cmd        (cmd),        // strobes from the bus controller
      .ad_out     (ad_out),
      .irq        (irq),
      .intr       (intr),
      .intc_drive (intc_drive),
      .intc_data  (intc_data)
   );

endmodule

`default_nettype wire

// ==== verif/cpu_bus_assertions.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// timing assertions for the processor sheet
// clock enable spacing, strobe rules, aen and ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module cpu_bus_assertions (
   input logic                    clk_100,
   input logic                    rst_n,
   input logic                    cpu_clk_en,
   input logic                    pclk_en,
   input logic                    ale,
   input pc_bus_pkg::bus_cmd_t    cmd,
   input pc_bus_pkg::bus_status_e s_n,
   input logic                    aen_n,
   input logic                    addr_oe,
   input logic                    sys_d_oe,
   input logic                    ready
);
   import pc_bus_pkg::*;

   int         gap;          // cycles since the last enable
   logic       seen_en;
   logic       en_par;       // high on every second enable
   logic [4:0] cmd_bits;
   logic       any_strobe;

   assign cmd_bits   = cmd;
   assign any_strobe = ~&cmd_bits;

   always_ff @(posedge clk_100 or negedge rst_n) begin
      if (!rst_n) begin
         gap     <= 0;
         seen_en <= 1'b0;
         en_par  <= 1'b0;
      end else if (cpu_clk_en) begin
         gap     <= 0;
         seen_en <= 1'b1;
         en_par  <= ~en_par;
      end else begin
         gap <= gap + 1;
      end
   end

   en_spacing: assert property (@(posedge clk_100) disable iff (!rst_n)
      cpu_clk_en && seen_en |-> gap == cpu_clk_div - 1)
      else $error("cpu_clk_en spacing is not the divider period");
   pclk_rate: assert property (@(posedge clk_100) disable iff (!rst_n)
      pclk_en == (cpu_clk_en && en_par))
      else $error("pclk_en is not on every second cpu_clk_en");
   one_strobe: assert property (@(posedge clk_100) disable iff (!rst_n)
      $countones(~cmd_bits) <= 1)
      else $error("more than one command strobe low");
   strobe_on_en: assert property (@(posedge clk_100) disable iff (!rst_n)
      $rose(any_strobe) |-> $past(cpu_clk_en) && $past(!aen_n))
      else $error("strobe asserted off the processor clock or with aen_n high");
   strobe_release: assert property (@(posedge clk_100) disable iff (!rst_n)
      cpu_clk_en && (s_n == passive) && any_strobe |=> !any_strobe)
      else $error("strobe not released after passive status");
   ale_pulse: assert property (@(posedge clk_100) disable iff (!rst_n)
      ale |=> !ale)
      else $error("ale longer than one cycle");
   ale_before_cmd: assert property (@(posedge clk_100) disable iff (!rst_n)
      ale |-> !any_strobe)
      else $error("ale while a strobe is low");
   ale_leads_cmd: assert property (@(posedge clk_100) disable iff (!rst_n)
      $rose(any_strobe) |-> $past(ale, cpu_clk_div))
      else $error("strobe without ale one processor clock earlier");
   aen_off: assert property (@(posedge clk_100) disable iff (!rst_n)
      aen_n |-> !addr_oe)
      else $error("addr_oe high while aen_n high");
   write_dir: assert property (@(posedge clk_100) disable iff (!rst_n)
      sys_d_oe |-> !cmd.iow_n || !cmd.memw_n)
      else $error("sys_d_oe high outside a write strobe");
   ready_on_en: assert property (@(posedge clk_100) disable iff (!rst_n)
      !$stable(ready) |-> $past(cpu_clk_en))
      else $error("ready changed off the processor clock");

endmodule

bind cpu_bus_sheet cpu_bus_assertions cpu_bus_assertions_i (.*);

`default_nettype wire

// ==== verif/tb_cpu_bus_sheet.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the processor sheet
// processor bus model, pic and ready stimulus
// data checks and closing error count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_bus_sheet;
   import pc_bus_pkg::*;

   logic        clk_100;
   logic        rst_n;
   logic        aen_n;
   logic        intr_cs_n;
   logic        xa0;
   logic        pwr_good;
   logic        rdy_wait_n;
   logic        dma_wait_n;
   bus_status_e s_n;
   logic [7:0]  ad_out;
   logic [7:0]  cpu_d;
   logic [7:0]  sys_d_in;
   logic [7:0]  irq;
   logic [7:0]  sys_d_out;
   logic [19:8] a_hi;
   addr_t       addr;
   logic        addr_oe;
   logic        sys_d_oe;
   logic        ale;
   logic        intr;
   logic        ready;
   logic        cpu_reset;
   logic        cpu_clk_en;
   logic        pclk_en;
   bus_cmd_t    cmd;
   int          errors;
   int          seed;
   int          n;          // wait loop counter
   int          r;
   logic [31:0] tmp;        // random word
   logic [7:0]  rd;
   logic [7:0]  wd;
   logic [7:0]  mask_exp;
   logic [7:0]  req_exp;    // model of the request register
   logic [vector_base_bits-1:0] vbase_exp;
   bus_status_e plan_st [6] = '{mem_read, mem_write, io_read, io_write, code_fetch, halt};

   cpu_bus_sheet cpu_bus_sheet_i (.*);

   initial begin
      clk_100 = 1'b0;
      forever #5 clk_100 = ~clk_100;           // 100 MHz
   end

   function automatic bus_cmd_t expected_cmd(input bus_status_e st);
      bus_cmd_t c;
      c = '{default: 1'b1};
      if (st == io_read) c.ior_n = 1'b0;
      if (st == io_write) c.iow_n = 1'b0;
      if (st == mem_read || st == code_fetch) c.memr_n = 1'b0;
      if (st == mem_write) c.memw_n = 1'b0;
      if (st == int_ack) c.inta_n = 1'b0;
      return c;
   endfunction

   function automatic logic [2:0] lowest_req(input logic [7:0] v);
      for (int i = 0; i < 8; i++) begin
         if (v[i]) return 3'(i);
      end
      return 3'd7;
   endfunction

   task automatic check_val(input string name, input logic [19:0] got, input logic [19:0] exp);
      if (got !== exp) begin
         errors++;
         $display("error at %0t: %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   // returns on the rising edge where cpu_clk_en is seen
   task automatic wait_tick;
      int k;
      k = 0;
      @(negedge clk_100);
      while (!cpu_clk_en && k < 50) begin
         @(negedge clk_100);
         k++;
      end
      if (!cpu_clk_en) begin
         errors++;
         $display("timeout while waiting for cpu_clk_en");
      end
      @(posedge clk_100);
   endtask

   // one processor bus cycle with status held two processor clocks
   task automatic bus_cycle(input bus_status_e st, input addr_t a, input logic [7:0] data,
                            input logic strobe_exp, output logic [7:0] rdata);
      bus_cmd_t exp_c;
      int k;
      exp_c = strobe_exp ? expected_cmd(st) : '{default: 1'b1};
      rdata = '0;
      wait_tick;
      s_n    <= st;
      a_hi   <= a[19:8];
      ad_out <= a[7:0];
      wait_tick;
      ad_out <= data;                          // data phase
      wait_tick;
      s_n    <= passive;
      @(negedge clk_100);
      check_val("cmd", 20'(cmd), 20'(exp_c));
      if (strobe_exp) begin
         check_val("addr", addr, a);
         check_val("addr_oe", 20'(addr_oe), 20'h1);
         check_val("sys_d_oe", 20'(sys_d_oe), 20'(st == io_write || st == mem_write));
         if (st == io_write || st == mem_write) begin
            check_val("sys_d_out", 20'(sys_d_out), 20'(data));
         end
         rdata = cpu_d;
      end
      k = 0;
      while (cmd !== bus_cmd_t'('1) && k < 30) begin
         @(negedge clk_100);
         k++;
      end
      if (cmd !== bus_cmd_t'('1)) begin
         errors++;
         $display("timeout while waiting for the strobe to release");
      end
      @(posedge clk_100);
   endtask

   initial begin
      errors = 0;
      seed = 47109;
      rst_n = 1'b0;
      s_n = passive;
      ad_out = '0;
      a_hi = '0;
      sys_d_in = '0;
      aen_n = 1'b0;
      intr_cs_n = 1'b1;
      xa0 = 1'b0;
      irq = '0;
      pwr_good = 1'b0;
      rdy_wait_n = 1'b1;
      dma_wait_n = 1'b1;
      req_exp = '0;
      repeat (4) @(posedge clk_100);
      rst_n <= 1'b1;
      wait_tick;                               // reset output updated with power good low
      @(negedge clk_100);
      check_val("cpu_reset", 20'(cpu_reset), 20'h1);
      @(posedge clk_100);
      pwr_good <= 1'b1;
      n = 0;
      while (cpu_reset && n < 60) begin
         @(negedge clk_100);
         n++;
      end
      if (cpu_reset) begin
         errors++;
         $display("timeout while waiting for cpu_reset to fall");
      end
      @(posedge clk_100);
      // plain memory and io cycles
      foreach (plan_st[i]) begin
         tmp = $random(seed);
         wd = tmp[27:20];
         sys_d_in <= tmp[7:0];
         bus_cycle(plan_st[i], addr_t'(tmp[19:0]), wd, plan_st[i] != halt, rd);
         if (plan_st[i] == mem_read || plan_st[i] == io_read || plan_st[i] == code_fetch) begin
            check_val("cpu_d", 20'(rd), 20'(tmp[7:0]));
         end
      end
      // pic registers
      tmp = $random(seed);
      mask_exp = tmp[7:0] & 8'h6b;
      vbase_exp = tmp[15:11];
      intr_cs_n <= 1'b0;
      xa0 <= 1'b1;
      bus_cycle(io_write, 20'h00021, mask_exp, 1'b1, rd);
      xa0 <= 1'b0;
      bus_cycle(io_write, 20'h00020, {vbase_exp, 3'b000}, 1'b1, rd);
      xa0 <= 1'b1;
      bus_cycle(io_read, 20'h00021, 8'h00, 1'b1, rd);
      check_val("mask", 20'(rd), 20'(mask_exp));
      // random request edges and acknowledges
      for (r = 0; r < 6; r++) begin
         irq <= '0;
         repeat (2) @(posedge clk_100);
         tmp = $random(seed);
         irq <= tmp[7:0];
         req_exp = req_exp | tmp[7:0];
         repeat (3) @(posedge clk_100);
         @(negedge clk_100);
         check_val("intr", 20'(intr), 20'(|(req_exp & ~mask_exp)));
         @(posedge clk_100);
         n = 0;
         while (|(req_exp & ~mask_exp) && n < 8) begin
            bus_cycle(int_ack, 20'h00000, 8'h00, 1'b1, rd);
            check_val("vector", 20'(rd), 20'({vbase_exp, lowest_req(req_exp & ~mask_exp)}));
            req_exp[lowest_req(req_exp & ~mask_exp)] = 1'b0;
            n++;
         end
         xa0 <= 1'b0;
         bus_cycle(io_read, 20'h00020, 8'h00, 1'b1, rd);
         check_val("request", 20'(rd), 20'(req_exp));
      end
      intr_cs_n <= 1'b1;
      // ready follows the wait input
      @(negedge clk_100);
      check_val("ready", 20'(ready), 20'h1);   // both wait inputs released
      @(posedge clk_100);
      rdy_wait_n <= 1'b0;
      n = 0;
      while (ready && n < 23) begin
         @(negedge clk_100);
         n++;
      end
      if (ready) begin
         errors++;
         $display("ready did not drop within 23 cycles of rdy_wait_n");
      end
      @(posedge clk_100);
      rdy_wait_n <= 1'b1;
      // bus given to dma
      aen_n <= 1'b1;
      @(negedge clk_100);
      check_val("addr_oe", 20'(addr_oe), 20'h0);
      @(posedge clk_100);
      bus_cycle(mem_write, 20'h12345, 8'h5a, 1'b0, rd);
      aen_n <= 1'b0;
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb.f ====
logic/pc_bus_pkg.sv
logic/clock_gen.sv
logic/bus_controller.sv
logic/interrupt_controller.sv
logic/cpu_bus_sheet.sv
verif/cpu_bus_assertions.sv
verif/tb_cpu_bus_sheet.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the processor sheet testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_cpu_bus_sheet -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation returned status $status"
   exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
   exit 0
fi
exit 1
